/* board_pkg.sv */
/* Board control package
   Register map, timing constants and bus structs shared by the control blocks */
package board_pkg;

   //////////////////////////////////////////////////
   // Timing constants
   //////////////////////////////////////////////////
   localparam int HOLDOFF_CYCLES        = 64;    // Hardware uses 65536
   localparam int HOLDOFF_W             = $clog2(HOLDOFF_CYCLES + 1);

   localparam int SPI_DIV               = 4;     // Bus cycles per SCLK half period
   localparam int SPI_BITS              = 24;    // One codec register access
   localparam int SPI_DIV_W             = $clog2(SPI_DIV + 1);
   localparam int SPI_BIT_W             = $clog2(SPI_BITS);

   localparam int PPS_PERIOD_CYCLES     = 1000;  // Scaled down for simulation
   localparam int TEN_MHZ_PERIOD_CYCLES = 10;
   localparam int REF_TOL               = 2;     // Allowed period error in cycles
   localparam int LOCK_COUNT            = 3;     // Good periods before lock
   localparam int REF_CNT_W             = $clog2(PPS_PERIOD_CYCLES + REF_TOL + 2);
   localparam int LOCK_W                = $clog2(LOCK_COUNT + 1);

   //////////////////////////////////////////////////
   // Register map
   //////////////////////////////////////////////////
   localparam logic [7:0] REG_FE_GPIO   = 8'h10; // Front-end word
   localparam logic [7:0] REG_MISC_OUTS = 8'h11; // Reference select bits
   localparam logic [7:0] REG_SPI_DATA  = 8'h12; // Write starts a transfer

   localparam logic [7:0] RB_FE_GPIO    = 8'h10;
   localparam logic [7:0] RB_SPI        = 8'h20;
   localparam logic [7:0] RB_STATUS     = 8'h21; // {board_ready, spi_busy, ref_locked}

   // Bit positions inside the misc register
   localparam int MISC_REF_SEL_BIT      = 0;
   localparam int MISC_PPS_BIT          = 1;

   //////////////////////////////////////////////////
   // Shared structs
   //////////////////////////////////////////////////
   typedef struct packed {
      logic        stb;   // Single cycle write strobe
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   typedef struct packed {
      logic sclk;
      logic mosi;
      logic sen;          // Active low
   } spi_pins_t;

   typedef struct packed {
      logic pa_en;
      logic sel_rx_rx2;
      logic sel_trx_tx;
      logic sel_rx_trx;
      logic sel_trx_rx;
      logic led_trx_r;    // LEDs all active low
      logic led_trx_g;
      logic led_rx2_g;
      logic led_s0;       // Reference locked
      logic led_s1;       // Reference level
   } fe_pins_t;

   typedef struct packed {
      logic ref_sel;        // Request and use 10 MHz input
      logic ext_ref_is_pps; // PPS wins over 10 MHz
   } ref_ctrl_t;

   // Pins after reset with switches off and LEDs dark
   localparam fe_pins_t FE_PINS_IDLE = '{
      pa_en: 1'b0, sel_rx_rx2: 1'b0, sel_trx_tx: 1'b0, sel_rx_trx: 1'b0, sel_trx_rx: 1'b0,
      led_trx_r: 1'b1, led_trx_g: 1'b1, led_rx2_g: 1'b1, led_s0: 1'b1, led_s1: 1'b1
   };

endpackage

/* board_top.sv */
/* Board control top
   Wires reset hold-off, settings registers, codec SPI and reference lock detection */
`timescale 1ns/1ps

module board_top import board_pkg::*; (
   input  logic        bus_clk,
   input  logic        reset_global,
   input  logic        locked,          // Clock generator lock
   input  set_bus_t    set_bus,
   input  logic [7:0]  rb_addr,
   output logic [31:0] rb_data,
   output logic        board_ready,
   output logic        cat_spi_en,      // Codec SPI enable, active low
   output logic        cat_spi_di,
   output logic        cat_spi_clk,
   input  logic        cat_spi_do,
   output logic        cat_resetn,
   output fe_pins_t    fe,
   input  logic        pps_in,
   input  logic        clkin_10mhz,
   output logic        clkin_10mhz_req
);

   logic                bus_rst;
   ref_ctrl_t           ref_ctrl;
   logic                ref_locked;
   logic                ref_level;
   spi_pins_t           spi;
   logic                spi_start;
   logic                spi_busy;
   logic [SPI_BITS-1:0] spi_tx_word;
   logic [SPI_BITS-1:0] spi_rx_word;

   //////////////////////////////////////////////////
   // Reset
   //////////////////////////////////////////////////
   reset_holdoff reset_holdoff_i (
      .bus_clk      (bus_clk),
      .reset_global (reset_global),
      .locked       (locked),
      .bus_rst      (bus_rst),
      .board_ready  (board_ready)
   );

   assign cat_resetn = ~reset_global;   // Codec reset is active low

   //////////////////////////////////////////////////
   // Settings and front-end
   //////////////////////////////////////////////////
   settings_regs settings_regs_i (
      .bus_clk     (bus_clk),
      .bus_rst     (bus_rst),
      .set_bus     (set_bus),
      .rb_addr     (rb_addr),
      .rb_data     (rb_data),
      .ref_locked  (ref_locked),
      .ref_level   (ref_level),
      .spi_busy    (spi_busy),
      .spi_rx_word (spi_rx_word),
      .board_ready (board_ready),
      .spi_start   (spi_start),
      .spi_tx_word (spi_tx_word),
      .ref_ctrl    (ref_ctrl),
      .fe          (fe)
   );

   //////////////////////////////////////////////////
   // Codec SPI
   //////////////////////////////////////////////////
   spi_master spi_master_i (
      .bus_clk     (bus_clk),
      .bus_rst     (bus_rst),
      .spi_start   (spi_start),
      .spi_tx_word (spi_tx_word),
      .miso        (cat_spi_do),
      .spi         (spi),
      .spi_busy    (spi_busy),
      .spi_rx_word (spi_rx_word)
   );

   // Codec is the only slave, so data and clock only toggle while enabled
   assign cat_spi_en  = spi.sen;
   assign cat_spi_di  = ~spi.sen & spi.mosi;
   assign cat_spi_clk = ~spi.sen & spi.sclk;

   //////////////////////////////////////////////////
   // External reference
   //////////////////////////////////////////////////
   ref_lock_detect ref_lock_detect_i (
      .bus_clk     (bus_clk),
      .bus_rst     (bus_rst),
      .ref_ctrl    (ref_ctrl),
      .pps_in      (pps_in),
      .clkin_10mhz (clkin_10mhz),
      .ref_locked  (ref_locked),
      .ref_level   (ref_level)
   );

   assign clkin_10mhz_req = ref_ctrl.ref_sel;   // Power up the 10 MHz input buffer

endmodule

/* ref_lock_detect.sv */
/* Reference lock detector
   Selects PPS or 10 MHz, synchronizes it and declares lock from measured periods */
`timescale 1ns/1ps

module ref_lock_detect import board_pkg::*; (
   input  logic      bus_clk,
   input  logic      bus_rst,
   input  ref_ctrl_t ref_ctrl,
   input  logic      pps_in,
   input  logic      clkin_10mhz,
   output logic      ref_locked,
   output logic      ref_level
);

   logic                 ext_ref;      // Selected raw reference
   logic [2:0]           ref_sync;     // Two sync stages plus edge delay
   logic                 ref_rise;
   ref_ctrl_t            mode_q;
   logic                 mode_change;
   logic [REF_CNT_W-1:0] period_cnt;   // Cycles since last edge
   logic [REF_CNT_W-1:0] expected;
   logic [REF_CNT_W-1:0] limit;        // Give up past this count
   logic                 period_ok;
   logic                 timeout;
   logic [LOCK_W-1:0]    good_cnt;

   // PPS first, then 10 MHz, else nothing
   assign ext_ref = ref_ctrl.ext_ref_is_pps ? pps_in :
                    ref_ctrl.ref_sel        ? clkin_10mhz : 1'b0;

   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         ref_sync <= '0;
      end else begin
         ref_sync <= {ref_sync[1:0], ext_ref};
      end
   end

   assign ref_rise    = ref_sync[1] & ~ref_sync[2];
   assign ref_level   = ref_sync[1];
   assign mode_change = (ref_ctrl != mode_q);

   // Period window for the current mode
   assign expected  = ref_ctrl.ext_ref_is_pps ? REF_CNT_W'(PPS_PERIOD_CYCLES) :
                                                REF_CNT_W'(TEN_MHZ_PERIOD_CYCLES);
   assign limit     = expected + REF_CNT_W'(REF_TOL + 1);
   assign period_ok = (period_cnt + REF_CNT_W'(REF_TOL) >= expected) &&
                      (period_cnt <= expected + REF_CNT_W'(REF_TOL));
   assign timeout   = (period_cnt == limit);

   //////////////////////////////////////////////////
   // Period measurement and lock
   //////////////////////////////////////////////////
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         mode_q     <= '0;
         period_cnt <= '0;
         good_cnt   <= '0;
         ref_locked <= 1'b0;
      end else begin
         mode_q <= ref_ctrl;
         if (mode_change) begin            // Start over in the new mode
            period_cnt <= '0;
            good_cnt   <= '0;
            ref_locked <= 1'b0;
         end else if (ref_rise) begin
            period_cnt <= REF_CNT_W'(1);   // Edge cycle counts as one
            if (period_ok) begin
               if (good_cnt != LOCK_W'(LOCK_COUNT)) begin
                  good_cnt <= good_cnt + 1'b1;
               end
               if (good_cnt >= LOCK_W'(LOCK_COUNT - 1)) begin
                  ref_locked <= 1'b1;
               end
            end else begin
               good_cnt   <= '0;
               ref_locked <= 1'b0;
            end
         end else if (timeout) begin       // Reference gone, hold count at limit
            good_cnt   <= '0;
            ref_locked <= 1'b0;
         end else begin
            period_cnt <= period_cnt + 1'b1;
         end
      end
   end

   // No reference selected means no edges can rebuild lock
   a_no_mode_no_lock: assert property (@(posedge bus_clk) disable iff (bus_rst)
      (!ref_ctrl.ref_sel && !ref_ctrl.ext_ref_is_pps) |=> !ref_locked);

endmodule

/* reset_holdoff.sv */
/* Reset hold-off
   Waits for clock lock plus a settle count, then releases a synchronized bus reset */
`timescale 1ns/1ps

module reset_holdoff import board_pkg::*; (
   input  logic bus_clk,
   input  logic reset_global,
   input  logic locked,
   output logic bus_rst,
   output logic board_ready
);

   logic                 hold_rst;      // Global reset or lost lock
   logic [HOLDOFF_W-1:0] holdoff_cnt;
   logic                 clocks_ready;  // Lock held long enough
   logic                 rst_meta;      // First synchronizer stage

   assign hold_rst = reset_global | ~locked;

   // Hold-off counter
   // Restarts on every loss of lock
   always_ff @(posedge bus_clk or posedge hold_rst) begin
      if (hold_rst) begin
         holdoff_cnt  <= '0;
         clocks_ready <= 1'b0;
      end else if (!clocks_ready) begin
         holdoff_cnt  <= holdoff_cnt + 1'b1;
         clocks_ready <= (holdoff_cnt == HOLDOFF_W'(HOLDOFF_CYCLES - 1)); // Set on count N
      end
   end

   // Async assert, two-stage sync release
   always_ff @(posedge bus_clk or posedge hold_rst) begin
      if (hold_rst) begin
         rst_meta <= 1'b1;
         bus_rst  <= 1'b1;
      end else begin
         rst_meta <= ~clocks_ready;
         bus_rst  <= rst_meta;       // Falls 2 cycles after clocks_ready
      end
   end

   assign board_ready = ~bus_rst;

   // Lost lock must show on bus_rst by the next edge
   a_rst_on_unlock: assert property (@(posedge bus_clk) disable iff (reset_global)
      !locked |=> bus_rst);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the board control testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f sources.f --top-module tb_board_top
output="$(./obj_dir/Vtb_board_top)"
echo "$output"
if echo "$output" | grep -q "test passed"; then
   exit 0
fi
exit 1

/* settings_regs.sv */
/* Settings registers
   Decodes bus writes into front-end, reference and SPI controls with registered readback */
`timescale 1ns/1ps

module settings_regs import board_pkg::*; (
   input  logic                bus_clk,
   input  logic                bus_rst,
   input  set_bus_t            set_bus,
   input  logic [7:0]          rb_addr,
   output logic [31:0]         rb_data,
   input  logic                ref_locked,
   input  logic                ref_level,
   input  logic                spi_busy,
   input  logic [SPI_BITS-1:0] spi_rx_word,
   input  logic                board_ready,
   output logic                spi_start,
   output logic [SPI_BITS-1:0] spi_tx_word,
   output ref_ctrl_t           ref_ctrl,
   output fe_pins_t            fe
);

   logic [7:0] fe_word;   // Software front-end word
   ref_ctrl_t  misc_q;    // Misc register before the output flop
   logic       wr_fe;
   logic       wr_misc;
   logic       wr_spi;

   //////////////////////////////////////////////////
   // Write decode
   //////////////////////////////////////////////////
   assign wr_fe   = set_bus.stb && (set_bus.addr == REG_FE_GPIO);
   assign wr_misc = set_bus.stb && (set_bus.addr == REG_MISC_OUTS);
   assign wr_spi  = set_bus.stb && (set_bus.addr == REG_SPI_DATA);

   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         fe_word   <= '0;
         misc_q    <= '0;
         spi_start <= 1'b0;
      end else begin
         spi_start <= wr_spi;       // One pulse per write
         if (wr_fe) begin
            fe_word <= set_bus.data[7:0];
         end
         if (wr_misc) begin
            misc_q.ref_sel        <= set_bus.data[MISC_REF_SEL_BIT];
            misc_q.ext_ref_is_pps <= set_bus.data[MISC_PPS_BIT];
         end
      end
   end

   // SPI word rides along with the start pulse
   always_ff @(posedge bus_clk) begin
      if (wr_spi) begin
         spi_tx_word <= set_bus.data[SPI_BITS-1:0];
      end
   end

   //////////////////////////////////////////////////
   // Output registers
   //////////////////////////////////////////////////
   // Second flop stage near the pins, 2 cycles after the strobe
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         fe       <= FE_PINS_IDLE;
         ref_ctrl <= '0;
      end else begin
         fe.pa_en      <= fe_word[7];
         fe.sel_rx_rx2 <= fe_word[6];
         fe.sel_trx_tx <= fe_word[5];
         fe.sel_rx_trx <= fe_word[4];
         fe.sel_trx_rx <= fe_word[3];
         fe.led_trx_r  <= ~fe_word[0];   // LEDs sink current
         fe.led_trx_g  <= ~fe_word[1];
         fe.led_rx2_g  <= ~fe_word[2];
         fe.led_s0     <= ~ref_locked;   // Lit when locked
         fe.led_s1     <= ~ref_level;    // Blinks with the reference
         ref_ctrl      <= misc_q;
      end
   end

   //////////////////////////////////////////////////
   // Readback
   //////////////////////////////////////////////////
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         rb_data <= '0;
      end else begin
         case (rb_addr)
            RB_FE_GPIO: rb_data <= {24'd0, fe_word};
            RB_SPI:     rb_data <= {{(32 - SPI_BITS){1'b0}}, spi_rx_word};
            RB_STATUS:  rb_data <= {29'd0, board_ready, spi_busy, ref_locked};
            default:    rb_data <= '0;
         endcase
      end
   end

   // Strobes are single cycle so SPI starts never come back to back
   a_spi_start_pulse: assert property (@(posedge bus_clk) disable iff (bus_rst)
      spi_start |=> !spi_start);

endmodule

/* sources.f */
board_pkg.sv
reset_holdoff.sv
settings_regs.sv
spi_master.sv
ref_lock_detect.sv
board_top.sv
tb_board_top.sv

/* spi_master.sv */
/* SPI master
   Mode 0 shifter for 24-bit codec accesses, MSB first, with captured read word */
`timescale 1ns/1ps

module spi_master import board_pkg::*; (
   input  logic                bus_clk,
   input  logic                bus_rst,
   input  logic                spi_start,
   input  logic [SPI_BITS-1:0] spi_tx_word,
   input  logic                miso,
   output spi_pins_t           spi,
   output logic                spi_busy,
   output logic [SPI_BITS-1:0] spi_rx_word
);

   logic                 sclk_q;
   logic                 sen_q;
   logic [SPI_DIV_W-1:0] div_cnt;     // Cycles within a half period
   logic [SPI_BIT_W-1:0] bit_cnt;
   logic                 half_done;
   logic                 last_bit;
   logic                 sclk_rise;   // Sample MISO
   logic                 sclk_fall;   // Advance MOSI
   logic                 load;
   logic [SPI_BITS-1:0]  tx_shift;
   logic [SPI_BITS-1:0]  rx_shift;

   assign half_done = (div_cnt == SPI_DIV_W'(SPI_DIV - 1));
   assign last_bit  = (bit_cnt == SPI_BIT_W'(SPI_BITS - 1));
   assign sclk_rise = spi_busy && half_done && !sclk_q;
   assign sclk_fall = spi_busy && half_done && sclk_q;
   assign load      = spi_start && !spi_busy;   // Starts while busy are dropped

   //////////////////////////////////////////////////
   // Transfer control
   //////////////////////////////////////////////////
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         spi_busy    <= 1'b0;
         sen_q       <= 1'b1;
         sclk_q      <= 1'b0;
         div_cnt     <= '0;
         bit_cnt     <= '0;
         spi_rx_word <= '0;
      end else if (load) begin
         spi_busy <= 1'b1;
         sen_q    <= 1'b0;        // Enable drops the cycle after start
         div_cnt  <= '0;
         bit_cnt  <= '0;
      end else if (spi_busy) begin
         div_cnt <= half_done ? '0 : div_cnt + 1'b1;
         if (half_done) begin
            sclk_q <= ~sclk_q;
         end
         if (sclk_fall) begin
            if (last_bit) begin
               sen_q       <= 1'b1;     // Done after last falling edge
               spi_busy    <= 1'b0;
               spi_rx_word <= rx_shift; // Present the full read word
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // Data shifters
   //////////////////////////////////////////////////
   always_ff @(posedge bus_clk) begin
      if (load) begin
         tx_shift <= spi_tx_word;
      end else if (sclk_fall) begin
         tx_shift <= {tx_shift[SPI_BITS-2:0], 1'b0}; // Next bit while SCLK low
      end
      if (sclk_rise) begin
         rx_shift <= {rx_shift[SPI_BITS-2:0], miso};
      end
   end

   assign spi = '{sclk: sclk_q, mosi: tx_shift[SPI_BITS-1], sen: sen_q};

   // Clock parks low outside a transfer
   a_sclk_idle: assert property (@(posedge bus_clk) disable iff (bus_rst)
      spi.sen |-> !spi.sclk);

   // Enable and busy move together
   a_sen_busy: assert property (@(posedge bus_clk) disable iff (bus_rst)
      spi.sen != spi_busy);

endmodule

/* tb_board_top.sv */
/* Board control testbench
   Directed tests for hold-off, front-end pins, codec SPI and reference lock */
`timescale 1ns/1ps

module tb_board_top import board_pkg::*; ();

   logic        bus_clk;
   logic        reset_global;
   logic        locked;
   set_bus_t    set_bus;
   logic [7:0]  rb_addr;
   logic [31:0] rb_data;
   logic        board_ready;
   logic        cat_spi_en;
   logic        cat_spi_di;
   logic        cat_spi_clk;
   logic        cat_spi_do;
   logic        cat_resetn;
   fe_pins_t    fe;
   logic        pps_in;
   logic        clkin_10mhz;
   logic        clkin_10mhz_req;

   int          errors = 0;     // Wrong values
   int          failures = 0;   // Timeouts and missing events
   logic [31:0] rng_state = 32'hdbdb_6e3b;

   board_top UUT (
      .bus_clk         (bus_clk),
      .reset_global    (reset_global),
      .locked          (locked),
      .set_bus         (set_bus),
      .rb_addr         (rb_addr),
      .rb_data         (rb_data),
      .board_ready     (board_ready),
      .cat_spi_en      (cat_spi_en),
      .cat_spi_di      (cat_spi_di),
      .cat_spi_clk     (cat_spi_clk),
      .cat_spi_do      (cat_spi_do),
      .cat_resetn      (cat_resetn),
      .fe              (fe),
      .pps_in          (pps_in),
      .clkin_10mhz     (clkin_10mhz),
      .clkin_10mhz_req (clkin_10mhz_req)
   );

   initial begin
      bus_clk = 1'b0;
      forever #5 bus_clk = ~bus_clk;   // 100 MHz bus clock
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////
   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      rng_state = x;
      return x;
   endfunction

   // Pin map of the front-end word with active low LEDs
   function automatic fe_pins_t fe_expected(input logic [7:0] word, input logic ref_lock,
                                            input logic level);
      fe_pins_t f;
      f.pa_en      = word[7];
      f.sel_rx_rx2 = word[6];
      f.sel_trx_tx = word[5];
      f.sel_rx_trx = word[4];
      f.sel_trx_rx = word[3];
      f.led_trx_r  = ~word[0];
      f.led_trx_g  = ~word[1];
      f.led_rx2_g  = ~word[2];
      f.led_s0     = ~ref_lock;
      f.led_s1     = ~level;
      return f;
   endfunction

   task automatic flag_mismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      errors++;
      $display("[ERROR] %0d ns: %s expected 0x%0h, actual 0x%0h", $time, name, expected, actual);
   endtask

   task automatic count_failure(input string what);
      failures++;
      $display("%0d ns: %s", $time, what);
   endtask

   // One-cycle strobe that returns on the falling edge after it was taken
   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      set_bus = '{stb: 1'b1, addr: addr, data: data};
      @(negedge bus_clk);
      set_bus.stb = 1'b0;
   endtask

   task automatic read_back(input logic [7:0] addr, output logic [31:0] data);
      rb_addr = addr;
      @(negedge bus_clk);
      data = rb_data;                  // Registered with one cycle latency
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////
   task automatic holdoff_and_reset();
      int n;
      int cyc;
      for (n = 0; n < 8; n++) begin
         @(negedge bus_clk);
         if (cat_resetn !== 1'b0) flag_mismatch("cat_resetn", 32'(0), 32'(cat_resetn));
         if (board_ready !== 1'b0) flag_mismatch("board_ready", 32'(0), 32'(board_ready));
      end
      // Idle pin levels while held in reset
      if (cat_spi_en !== 1'b1) flag_mismatch("cat_spi_en", 32'(1), 32'(cat_spi_en));
      if (cat_spi_clk !== 1'b0) flag_mismatch("cat_spi_clk", 32'(0), 32'(cat_spi_clk));
      if (fe !== fe_expected(8'h00, 1'b0, 1'b0)) begin
         flag_mismatch("fe", 32'(fe_expected(8'h00, 1'b0, 1'b0)), 32'(fe));
      end
      if (clkin_10mhz_req !== 1'b0) flag_mismatch("clkin_10mhz_req", 32'(0), 32'(clkin_10mhz_req));
      reset_global = 1'b0;
      for (n = 0; n < 10; n++) begin   // No lock yet
         @(negedge bus_clk);
         if (board_ready !== 1'b0) flag_mismatch("board_ready", 32'(0), 32'(board_ready));
      end
      if (cat_resetn !== 1'b1) flag_mismatch("cat_resetn", 32'(1), 32'(cat_resetn));
      locked = 1'b1;
      // Exactly the count plus two sync stages
      for (n = 1; n <= HOLDOFF_CYCLES + 2; n++) begin
         @(negedge bus_clk);
         if (board_ready !== (n == HOLDOFF_CYCLES + 2)) begin
            flag_mismatch("board_ready", 32'(n == HOLDOFF_CYCLES + 2), 32'(board_ready));
         end
      end
      locked = 1'b0;
      cyc = 0;
      while (board_ready && cyc < 3) begin
         @(negedge bus_clk);
         cyc++;
      end
      if (board_ready) count_failure("board_ready still high 3 cycles after locked fell");
      locked = 1'b1;
      cyc = 0;
      while (!board_ready && cyc < HOLDOFF_CYCLES + 10) begin
         @(negedge bus_clk);
         cyc++;
      end
      if (!board_ready) count_failure("board_ready did not return after lock came back");
   endtask

   task automatic frontend_mapping();
      logic [31:0] value;
      logic [31:0] rd;
      fe_pins_t    prev;
      fe_pins_t    want;
      int          i;
      prev = fe_expected(8'h00, 1'b0, 1'b0);   // Word cleared by the last reset
      for (i = 0; i < 10; i++) begin
         value = next_random();
         want  = fe_expected(value[7:0], 1'b0, 1'b0);
         write_setting(REG_FE_GPIO, value);
         if (fe !== prev) flag_mismatch("fe after 1 cycle", 32'(prev), 32'(fe));
         @(negedge bus_clk);
         if (fe !== want) flag_mismatch("fe after 2 cycles", 32'(want), 32'(fe));
         read_back(RB_FE_GPIO, rd);
         if (rd !== {24'd0, value[7:0]}) flag_mismatch("RB_FE_GPIO", {24'd0, value[7:0]}, rd);
         prev = want;
      end
   endtask

   // Slave model and monitor run on bus_clk falling edges
   task automatic spi_transfer();
      logic [31:0]         rnd;
      logic [SPI_BITS-1:0] tx_word;
      logic [SPI_BITS-1:0] slave_word;
      logic [SPI_BITS-1:0] mosi_seen;
      logic [31:0]         rd;
      logic                prev_clk;
      int                  bits;
      int                  miso_idx;
      int                  cyc;
      rnd        = next_random();
      tx_word    = rnd[SPI_BITS-1:0];
      rnd        = next_random();
      slave_word = rnd[SPI_BITS-1:0];
      miso_idx   = SPI_BITS - 1;
      cat_spi_do = slave_word[miso_idx];     // MSB ready before first rise
      write_setting(REG_SPI_DATA, {8'h00, tx_word});
      cyc = 0;
      while (cat_spi_en && cyc < 10) begin
         @(negedge bus_clk);
         cyc++;
      end
      if (cat_spi_en) count_failure("cat_spi_en never went low after the SPI write");
      rb_addr   = RB_STATUS;
      bits      = 0;
      prev_clk  = 1'b0;
      mosi_seen = '0;
      while (!cat_spi_en && cyc < SPI_BITS * 2 * SPI_DIV + 20) begin
         if (cat_spi_clk && !prev_clk) begin
            mosi_seen = {mosi_seen[SPI_BITS-2:0], cat_spi_di};   // Capture on rise
            bits++;
            // Busy and ready bits set while unlocked
            if (rb_data !== 32'h0000_0006) flag_mismatch("RB_STATUS", 32'h0000_0006, rb_data);
         end
         if (!cat_spi_clk && prev_clk && miso_idx > 0) begin
            miso_idx--;
            cat_spi_do = slave_word[miso_idx];                   // Next bit after fall
         end
         prev_clk = cat_spi_clk;
         @(negedge bus_clk);
         cyc++;
      end
      if (!cat_spi_en) count_failure("SPI transfer did not end");
      // Fewer edges means the enable rose early
      if (bits != SPI_BITS) flag_mismatch("cat_spi_clk rising edges", 32'(SPI_BITS), 32'(bits));
      if (mosi_seen !== tx_word) flag_mismatch("cat_spi_di word", 32'(tx_word), 32'(mosi_seen));
      cyc = 0;
      read_back(RB_STATUS, rd);
      while (rd[1] && cyc < 20) begin
         read_back(RB_STATUS, rd);
         cyc++;
      end
      if (rd[1]) count_failure("SPI busy bit did not clear");
      if (cat_spi_clk !== 1'b0) flag_mismatch("cat_spi_clk", 32'(0), 32'(cat_spi_clk));
      if (cat_spi_di !== 1'b0) flag_mismatch("cat_spi_di", 32'(0), 32'(cat_spi_di));
      read_back(RB_SPI, rd);
      if (rd !== 32'(slave_word)) flag_mismatch("RB_SPI", 32'(slave_word), rd);
   endtask

   task automatic pps_lock();
      int   c;
      int   lock_at;
      logic level_seen;
      write_setting(REG_MISC_OUTS, 32'h0000_0002);  // PPS mode
      @(negedge bus_clk);
      rb_addr    = RB_STATUS;
      lock_at    = -1;
      level_seen = 1'b0;
      for (c = 0; c < (LOCK_COUNT + 2) * PPS_PERIOD_CYCLES && lock_at < 0; c++) begin
         pps_in = ((c % PPS_PERIOD_CYCLES) < 5);   // Short pulse each period
         @(negedge bus_clk);
         if (!fe.led_s1) level_seen = 1'b1;
         if (rb_data[0] && !fe.led_s0) lock_at = c;
      end
      if (lock_at < 0) count_failure("no PPS lock within LOCK_COUNT+2 periods");
      if (!level_seen) count_failure("led_s1 never lit during the PPS pulses");
      pps_in = 1'b0;
      c = 0;
      while (rb_data[0] && c < 2 * PPS_PERIOD_CYCLES) begin
         @(negedge bus_clk);
         c++;
      end
      if (rb_data[0]) count_failure("PPS lock held 2 periods after the pulses stopped");
      if (fe.led_s0 !== 1'b1) flag_mismatch("fe.led_s0", 32'(1), 32'(fe.led_s0));
   endtask

   task automatic ten_mhz_lock();
      int   c;
      logic got_lock;
      logic seen_lock;
      write_setting(REG_MISC_OUTS, 32'h0000_0001);  // 10 MHz with PPS off
      @(negedge bus_clk);
      if (clkin_10mhz_req !== 1'b1) flag_mismatch("clkin_10mhz_req", 32'(1), 32'(clkin_10mhz_req));
      rb_addr  = RB_STATUS;
      got_lock = 1'b0;
      for (c = 0; c < 20 * TEN_MHZ_PERIOD_CYCLES && !got_lock; c++) begin
         clkin_10mhz = ((c % TEN_MHZ_PERIOD_CYCLES) < TEN_MHZ_PERIOD_CYCLES / 2);
         @(negedge bus_clk);
         got_lock = rb_data[0];
      end
      if (!got_lock) count_failure("no lock on a 10-cycle reference");
      seen_lock = 1'b0;
      for (c = 0; c < 20 * 16; c++) begin
         clkin_10mhz = ((c % 16) < 8);              // 16-cycle period is outside tolerance
         @(negedge bus_clk);
         if (c >= 2 * 16 && rb_data[0]) seen_lock = 1'b1;   // Old lock drains first
      end
      if (seen_lock) count_failure("lock declared on a 16-cycle reference");
      clkin_10mhz = 1'b0;
   endtask

   //////////////////////////////////////////////////
   // Sequence
   //////////////////////////////////////////////////
   initial begin
      reset_global = 1'b1;
      locked       = 1'b0;
      set_bus      = '0;
      rb_addr      = '0;
      cat_spi_do   = 1'b0;
      pps_in       = 1'b0;
      clkin_10mhz  = 1'b0;
      holdoff_and_reset();
      frontend_mapping();
      spi_transfer();
      pps_lock();
      ten_mhz_lock();
      $display("errors: %0d, failures: %0d", errors, failures);
      if (errors == 0 && failures == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule
